/* source/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

  // 31:28 op, 27:25 func, 24:20 ra, 19:15 rb, 14:10 rc, 15:0 imm16
  typedef enum logic [3:0] {
    OP_ALU    = 4'h0,  // rc = ra func rb
    OP_ALUI   = 4'h1,  // ra = ra func sext(imm16)
    OP_LDI    = 4'h2,  // ra = sext(imm16), flags untouched
    OP_MUL    = 4'h3,  // {rc+1, rc} = ra * rb, func[0] set for signed
    OP_LOAD   = 4'h4,  // ra = mem[rb]
    OP_STORE  = 4'h5,  // mem[rb] = ra
    OP_BRANCH = 4'h6,  // func holds a cond_t
    OP_JR     = 4'h7,  // pc = ra
    OP_HALT   = 4'h8
  } op_t;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA
  } alu_func_t;

  // load/store func: [1:0] size, [2] sign-extend on load
  typedef enum logic [1:0] {
    SIZE_WORD = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_BYTE = 2'd2
  } mem_size_t;

  typedef enum logic [2:0] {
    COND_ALWAYS, COND_EQ, COND_NE, COND_LT, COND_LTU, COND_GE
  } cond_t;

  typedef enum logic [2:0] {
    S_FETCH, S_DECODE, S_EXECUTE, S_MUL_WAIT, S_MEM_ADDR, S_MEM_ACCESS, S_WRITEBACK, S_HALTED
  } ctrl_state_t;

  typedef enum logic [1:0] {PC_HOLD, PC_INC, PC_ALU, PC_REG} pc_sel_t;
  typedef enum logic [1:0] {MDR_HOLD, MDR_STORE, MDR_LOAD} mdr_sel_t;
  typedef enum logic [1:0] {REG_ALU, REG_MDR, REG_MUL_LO, REG_MUL_HI} reg_sel_t;
  typedef enum logic {A1_REG, A1_PC} alu1_sel_t;
  typedef enum logic [1:0] {A2_REG, A2_IMM, A2_BOFF} alu2_sel_t;

  typedef struct packed {
    logic z;
    logic n;
    logic c;  // borrow after sub
    logic v;
  } ccr_t;

  typedef struct packed {
    op_t       op;
    alu_func_t func;
    logic [4:0] ra;
    logic [4:0] rb;
    logic [4:0] rc;
    logic [9:0] lo;  // low part of imm16
  } instr_t;

  typedef struct packed {
    pc_sel_t    pc_sel;
    logic       mar_sel;
    mdr_sel_t   mdr_sel;
    reg_sel_t   reg_sel;
    alu1_sel_t  alu1_sel;
    alu2_sel_t  alu2_sel;
    alu_func_t  alu_func;
    logic       reg_write;
    logic [4:0] raddr1;
    logic [4:0] raddr2;
    logic [4:0] waddr;
    logic       ir_write;
    logic       ccr_write;
    logic       addr_sel;  // 1 selects mar onto the bus
    logic       mul_start;
    logic       mul_signed;
    mem_size_t  mem_size;
    logic       load_signed;
  } ctrl_t;

  // imm16 overlaps rb[0], rc and lo
  function automatic logic [15:0] imm16(instr_t i);
    return {i.rb[0], i.rc, i.lo};
  endfunction

endpackage

`default_nettype wire

/* source/cpu_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_alu import cpu_pkg::*; (
  input wire [31:0] in1,
  input wire [31:0] in2,
  input wire alu_func_t func,
  output logic [31:0] result,
  output ccr_t flags
);

  logic [32:0] sum, diff;

  assign sum = {1'b0, in1} + {1'b0, in2};
  assign diff = {1'b0, in1} - {1'b0, in2};

  always_comb begin
    result = '0;
    flags.c = 1'b0;
    flags.v = 1'b0;
    case (func)
      ALU_ADD: begin
        result = sum[31:0];
        flags.c = sum[32];
        flags.v = (in1[31] == in2[31]) && (sum[31] != in1[31]);
      end
      ALU_SUB: begin
        result = diff[31:0];
        flags.c = diff[32];  // borrow, in1 < in2 unsigned
        flags.v = (in1[31] != in2[31]) && (diff[31] != in1[31]);
      end
      ALU_AND: result = in1 & in2;
      ALU_OR: result = in1 | in2;
      ALU_XOR: result = in1 ^ in2;
      ALU_SLL: result = in1 << in2[4:0];
      ALU_SRL: result = in1 >> in2[4:0];
      ALU_SRA: result = $signed(in1) >>> in2[4:0];
      default: result = '0;
    endcase
    flags.z = (result == 32'd0);
    flags.n = result[31];
  end

endmodule

`default_nettype wire

/* source/int_mul_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module int_mul_unit #(
  parameter int MUL_STAGES = 2
) (
  input wire clk,
  input wire reset_n,
  input wire start,
  input wire is_signed,
  input wire [31:0] a,
  input wire [31:0] b,
  output logic [63:0] product,
  output logic done
);

  logic [63:0] stage_q [MUL_STAGES];
  logic [MUL_STAGES-1:0] valid_q;
  logic signed [65:0] full_product;

  // 33-bit operands cover both signed and unsigned forms
  assign full_product = $signed({is_signed & a[31], a}) * $signed({is_signed & b[31], b});

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= start;
      for (int i = 1; i < MUL_STAGES; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // a stage only moves with its valid, so the last one holds
  always_ff @(posedge clk) begin
    if (start) begin
      stage_q[0] <= full_product[63:0];
    end
    for (int i = 1; i < MUL_STAGES; i++) begin
      if (valid_q[i-1]) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign product = stage_q[MUL_STAGES-1];
  assign done = valid_q[MUL_STAGES-1];

  a_done_latency: assert property (@(posedge clk) disable iff (!reset_n)
    start |-> ##MUL_STAGES done);

endmodule

`default_nettype wire

/* source/register_file.sv */
`timescale 1ns/100ps
`default_nettype none

module register_file (
  input wire clk,
  input wire reset_n,
  input wire [4:0] raddr1,
  input wire [4:0] raddr2,
  input wire [4:0] waddr,
  input wire [31:0] wdata,
  input wire wen,
  output logic [31:0] rdata1,
  output logic [31:0] rdata2
);

  logic [31:0] regs [32];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (waddr != 5'd0)) begin
      regs[waddr] <= wdata;
    end
  end

  // r0 is hardwired
  assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
  assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

`default_nettype wire

/* source/bus_lanes.sv */
`timescale 1ns/100ps
`default_nettype none

module bus_lanes import cpu_pkg::*; (
  input wire mem_size_t size,
  input wire load_signed,
  input wire [1:0] addr_low,
  input wire [31:0] store_data,
  input wire [31:0] readdata,
  output logic [31:0] writedata,
  output logic [31:0] load_data,
  output logic [3:0] byteenable
);

  logic [7:0] load_byte;
  logic [15:0] load_half;

  assign load_byte = readdata[8*addr_low +: 8];
  assign load_half = addr_low[1] ? readdata[31:16] : readdata[15:0];

  always_comb begin
    case (size)
      SIZE_HALF: begin
        byteenable = addr_low[1] ? 4'b1100 : 4'b0011;
        writedata = addr_low[1] ? {store_data[15:0], 16'h0000} : {16'h0000, store_data[15:0]};
        load_data = {{16{load_signed & load_half[15]}}, load_half};
      end
      SIZE_BYTE: begin
        byteenable = 4'b0001 << addr_low;
        writedata = {24'h000000, store_data[7:0]} << (8 * addr_low);  // unused lanes zero
        load_data = {{24{load_signed & load_byte[7]}}, load_byte};
      end
      default: begin
        byteenable = 4'b1111;
        writedata = store_data;
        load_data = readdata;
      end
    endcase
  end

endmodule

`default_nettype wire

/* source/cpu_control.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_control import cpu_pkg::*; #(
  parameter int MUL_STAGES = 2
) (
  input wire clk,
  input wire reset_n,
  input wire instr_t ir,
  input wire ccr_t ccr,
  input wire waitrequest,
  input wire mul_done,
  input wire [1:0] addr_low,
  output ctrl_t ctrl,
  output logic read,
  output logic write,
  output logic halt
);

  ctrl_state_t state, state_next;
  logic [2:0] fbits;
  logic xfer_done, is_load, taken;

  assign fbits = ir.func;
  assign is_load = (ir.op == OP_LOAD);
  assign xfer_done = (read | write) & ~waitrequest;

  always_comb begin
    case (cond_t'(ir.func))
      COND_ALWAYS: taken = 1'b1;
      COND_EQ: taken = ccr.z;
      COND_NE: taken = ~ccr.z;
      COND_LT: taken = ccr.n ^ ccr.v;
      COND_LTU: taken = ccr.c;
      COND_GE: taken = ~(ccr.n ^ ccr.v);
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    ctrl = '0;
    ctrl.raddr1 = ir.ra;
    ctrl.raddr2 = ir.rb;
    ctrl.alu_func = ir.func;
    state_next = state;
    case (state)
      S_FETCH: begin
        if (xfer_done) begin
          ctrl.ir_write = 1'b1;
          ctrl.pc_sel = PC_INC;
          state_next = S_DECODE;
        end
      end
      S_DECODE: begin
        case (ir.op)
          OP_ALU, OP_ALUI, OP_LDI, OP_MUL, OP_BRANCH, OP_JR: state_next = S_EXECUTE;
          OP_LOAD, OP_STORE: state_next = S_MEM_ADDR;
          default: state_next = S_HALTED;  // halt and unused opcodes
        endcase
      end
      S_EXECUTE: begin
        state_next = S_WRITEBACK;
        case (ir.op)
          OP_ALU: ctrl.ccr_write = 1'b1;
          OP_ALUI: begin
            ctrl.alu2_sel = A2_IMM;
            ctrl.ccr_write = 1'b1;
          end
          OP_LDI: begin
            ctrl.raddr1 = 5'd0;  // r0 + imm
            ctrl.alu2_sel = A2_IMM;
            ctrl.alu_func = ALU_ADD;
          end
          OP_MUL: begin
            ctrl.mul_start = 1'b1;
            ctrl.mul_signed = fbits[0];
            state_next = S_MUL_WAIT;
          end
          OP_BRANCH: begin
            ctrl.alu1_sel = A1_PC;
            ctrl.alu2_sel = A2_BOFF;
            ctrl.alu_func = ALU_ADD;
            if (taken) begin
              ctrl.pc_sel = PC_ALU;
            end
            state_next = S_FETCH;
          end
          default: begin
            ctrl.pc_sel = PC_REG;  // jump register
            state_next = S_FETCH;
          end
        endcase
      end
      S_MUL_WAIT: begin
        if (mul_done) begin
          ctrl.reg_write = 1'b1;
          ctrl.reg_sel = REG_MUL_LO;
          ctrl.waddr = ir.rc;
          state_next = S_WRITEBACK;
        end
      end
      S_MEM_ADDR: begin
        ctrl.mar_sel = 1'b1;
        if (!is_load) begin
          ctrl.mdr_sel = MDR_STORE;
        end
        state_next = S_MEM_ACCESS;
      end
      S_MEM_ACCESS: begin
        ctrl.addr_sel = 1'b1;
        ctrl.mem_size = mem_size_t'(fbits[1:0]);
        ctrl.load_signed = fbits[2];
        if (xfer_done) begin
          if (is_load) begin
            ctrl.mdr_sel = MDR_LOAD;
            state_next = S_WRITEBACK;
          end else begin
            state_next = S_FETCH;
          end
        end
      end
      S_WRITEBACK: begin
        ctrl.reg_write = 1'b1;
        state_next = S_FETCH;
        case (ir.op)
          OP_ALU: ctrl.waddr = ir.rc;
          OP_MUL: begin
            ctrl.reg_sel = REG_MUL_HI;
            ctrl.waddr = ir.rc + 5'd1;
            ctrl.reg_write = (ir.rc != 5'd31);  // no pair above r31
          end
          OP_LOAD: begin
            ctrl.reg_sel = REG_MDR;
            ctrl.waddr = ir.ra;
          end
          default: ctrl.waddr = ir.ra;
        endcase
      end
      default: state_next = S_HALTED;
    endcase
  end

  // strobes come from the next state so they are clean registers
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= S_FETCH;
      read <= 1'b0;
      write <= 1'b0;
      halt <= 1'b0;
    end else begin
      state <= state_next;
      read <= (state_next == S_FETCH) || ((state_next == S_MEM_ACCESS) && is_load);
      write <= (state_next == S_MEM_ACCESS) && !is_load;
      halt <= (state_next == S_HALTED);
    end
  end

  a_strobe_excl: assert property (@(posedge clk) disable iff (!reset_n)
    !(read && write));

  a_aligned: assert property (@(posedge clk) disable iff (!reset_n)
    (read || write) |-> (ctrl.mem_size != SIZE_WORD || addr_low == 2'b00) &&
                        (ctrl.mem_size != SIZE_HALF || !addr_low[0]));

  // product lands while still parked in the wait state
  a_mul_wait: assert property (@(posedge clk) disable iff (!reset_n)
    ctrl.mul_start |-> ##MUL_STAGES (state == S_MUL_WAIT && mul_done));

endmodule

`default_nettype wire

/* source/cpu_core.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_core import cpu_pkg::*; #(
  parameter int MUL_STAGES = 2,
  parameter logic [31:0] RESET_PC = 32'h0
) (
  input wire clk,
  input wire reset_n,
  input wire waitrequest,
  input wire [31:0] readdata,
  output logic [31:0] address,
  output logic read,
  output logic write,
  output logic [31:0] writedata,
  output logic [3:0] byteenable,
  output logic halt
);

  ctrl_t ctrl;
  instr_t ir;
  ccr_t ccr, alu_flags;
  logic [31:0] pc, pc_next, mar, mdr, mdr_next, aluval;
  logic [31:0] rdata1, rdata2, reg_wdata, alu_in1, alu_in2, alu_out;
  logic [31:0] imm_sext, load_data;
  logic [15:0] imm;
  logic [63:0] mul_product;
  logic mul_done;

  assign imm = imm16(ir);
  assign imm_sext = {{16{imm[15]}}, imm};
  assign address = ctrl.addr_sel ? mar : pc;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      pc <= RESET_PC;
      ir <= '0;
      ccr <= '0;
    end else begin
      pc <= pc_next;
      if (ctrl.ir_write) begin
        ir <= instr_t'(readdata);
      end
      if (ctrl.ccr_write) begin
        ccr <= alu_flags;
      end
    end
  end

  always_ff @(posedge clk) begin
    aluval <= alu_out;  // latched at the end of execute
    mdr <= mdr_next;
    if (ctrl.mar_sel) begin
      mar <= rdata2;
    end
  end

  always_comb begin
    case (ctrl.pc_sel)
      PC_INC: pc_next = pc + 32'd4;
      PC_ALU: pc_next = alu_out;  // branch target
      PC_REG: pc_next = rdata1;
      default: pc_next = pc;
    endcase
    case (ctrl.mdr_sel)
      MDR_STORE: mdr_next = rdata1;
      MDR_LOAD: mdr_next = load_data;
      default: mdr_next = mdr;
    endcase
    case (ctrl.reg_sel)
      REG_MDR: reg_wdata = mdr;
      REG_MUL_LO: reg_wdata = mul_product[31:0];
      REG_MUL_HI: reg_wdata = mul_product[63:32];
      default: reg_wdata = aluval;
    endcase
    alu_in1 = (ctrl.alu1_sel == A1_PC) ? pc : rdata1;
    case (ctrl.alu2_sel)
      A2_REG: alu_in2 = rdata2;
      A2_IMM: alu_in2 = imm_sext;
      A2_BOFF: alu_in2 = {imm_sext[29:0], 2'b00};  // word offset
      default: alu_in2 = '0;
    endcase
  end

  cpu_control #(.MUL_STAGES(MUL_STAGES)) ctl0 (
    .clk(clk),
    .reset_n(reset_n),
    .ir(ir),
    .ccr(ccr),
    .waitrequest(waitrequest),
    .mul_done(mul_done),
    .addr_low(address[1:0]),
    .ctrl(ctrl),
    .read(read),
    .write(write),
    .halt(halt)
  );

  cpu_alu alu0 (
    .in1(alu_in1),
    .in2(alu_in2),
    .func(ctrl.alu_func),
    .result(alu_out),
    .flags(alu_flags)
  );

  int_mul_unit #(.MUL_STAGES(MUL_STAGES)) mul0 (
    .clk(clk),
    .reset_n(reset_n),
    .start(ctrl.mul_start),
    .is_signed(ctrl.mul_signed),
    .a(rdata1),
    .b(rdata2),
    .product(mul_product),
    .done(mul_done)
  );

  register_file regs0 (
    .clk(clk),
    .reset_n(reset_n),
    .raddr1(ctrl.raddr1),
    .raddr2(ctrl.raddr2),
    .waddr(ctrl.waddr),
    .wdata(reg_wdata),
    .wen(ctrl.reg_write),
    .rdata1(rdata1),
    .rdata2(rdata2)
  );

  bus_lanes lanes0 (
    .size(ctrl.mem_size),
    .load_signed(ctrl.load_signed),
    .addr_low(address[1:0]),
    .store_data(mdr),
    .readdata(readdata),
    .writedata(writedata),
    .load_data(load_data),
    .byteenable(byteenable)
  );

endmodule

`default_nettype wire

/* verif/cpu_ref_model.svh */
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

typedef struct packed {
  logic        wr;
  logic [31:0] addr;
  logic [3:0]  be;
  logic [31:0] data;
} xfer_t;

logic [31:0] m_regs [32];
logic [3:0] m_flags;  // z n c v
logic [31:0] model_mem [logic [29:0]];
xfer_t exp_q [$];

// depends on every address bit
function automatic logic [31:0] fill_word(logic [31:0] addr);
  return ((addr ^ 32'h5a3c_96e1) * 32'h9e37_79b1) + {addr[15:0], addr[31:16]};
endfunction

function automatic logic [31:0] model_word(logic [31:0] addr);
  if (model_mem.exists(addr[31:2])) begin
    return model_mem[addr[31:2]];
  end
  return fill_word({addr[31:2], 2'b00});
endfunction

function automatic logic [31:0] merge_lanes(logic [31:0] old, logic [31:0] d, logic [3:0] be);
  logic [31:0] r;
  r = old;
  for (int i = 0; i < 4; i++) begin
    if (be[i]) r[8*i +: 8] = d[8*i +: 8];
  end
  return r;
endfunction

// returns {z, n, c, v, result}
function automatic logic [35:0] alu_eval(logic [31:0] a, logic [31:0] b, logic [2:0] f);
  logic [32:0] wide;
  logic [31:0] r;
  logic c;
  logic v;
  c = 1'b0;
  v = 1'b0;
  r = '0;
  case (f)
    3'd0: begin
      wide = {1'b0, a} + {1'b0, b};
      r = wide[31:0];
      c = wide[32];
      v = (a[31] == b[31]) && (r[31] != a[31]);
    end
    3'd1: begin
      r = a - b;
      c = (a < b);  // borrow
      v = (a[31] != b[31]) && (r[31] != a[31]);
    end
    3'd2: r = a & b;
    3'd3: r = a | b;
    3'd4: r = a ^ b;
    3'd5: r = a << b[4:0];
    3'd6: r = a >> b[4:0];
    default: r = $unsigned($signed(a) >>> b[4:0]);
  endcase
  return {(r == 32'd0), r[31], c, v, r};
endfunction

function automatic logic cond_holds(logic [2:0] f, logic [3:0] fl);
  case (f)
    3'd0: return 1'b1;
    3'd1: return fl[3];
    3'd2: return !fl[3];
    3'd3: return fl[2] ^ fl[0];
    3'd4: return fl[1];
    3'd5: return !(fl[2] ^ fl[0]);
    default: return 1'b0;
  endcase
endfunction

task automatic model_set(logic [4:0] r, logic [31:0] v);
  if (r != 5'd0) m_regs[r] = v;
endtask

task automatic model_run();
  logic [31:0] pc, iw, imm, addr, w, d;
  logic [35:0] ar;
  logic [63:0] prod;
  logic [4:0] ra, rb, rc;
  logic [2:0] f;
  logic [15:0] h;
  logic [3:0] be;
  logic done;
  pc = 32'h100;
  done = 1'b0;
  m_flags = '0;
  for (int i = 0; i < 32; i++) m_regs[i] = '0;
  while (!done) begin
    iw = model_word(pc);
    exp_q.push_back('{1'b0, pc, 4'h0, 32'h0});
    pc = pc + 32'd4;
    f = iw[27:25];
    ra = iw[24:20];
    rb = iw[19:15];
    rc = iw[14:10];
    imm = {{16{iw[15]}}, iw[15:0]};
    case (iw[31:28])
      4'h0: begin
        ar = alu_eval(m_regs[ra], m_regs[rb], f);
        m_flags = ar[35:32];
        model_set(rc, ar[31:0]);
      end
      4'h1: begin
        ar = alu_eval(m_regs[ra], imm, f);
        m_flags = ar[35:32];
        model_set(ra, ar[31:0]);
      end
      4'h2: model_set(ra, imm);
      4'h3: begin
        if (f[0]) prod = $signed({{32{m_regs[ra][31]}}, m_regs[ra]}) *
                         $signed({{32{m_regs[rb][31]}}, m_regs[rb]});
        else prod = {32'h0, m_regs[ra]} * {32'h0, m_regs[rb]};
        model_set(rc, prod[31:0]);
        if (rc != 5'd31) model_set(rc + 5'd1, prod[63:32]);
      end
      4'h4: begin
        addr = m_regs[rb];
        w = model_word(addr);
        exp_q.push_back('{1'b0, addr, 4'h0, 32'h0});
        h = addr[1] ? w[31:16] : w[15:0];
        case (f[1:0])
          2'd1: d = {{16{f[2] & h[15]}}, h};
          2'd2: d = {{24{f[2] & w[8*addr[1:0] + 7]}}, w[8*addr[1:0] +: 8]};
          default: d = w;
        endcase
        model_set(ra, d);
      end
      4'h5: begin
        addr = m_regs[rb];
        d = m_regs[ra];
        case (f[1:0])
          2'd1: begin
            be = addr[1] ? 4'b1100 : 4'b0011;
            d = addr[1] ? {d[15:0], 16'h0} : {16'h0, d[15:0]};
          end
          2'd2: begin
            be = 4'b0001 << addr[1:0];
            d = {24'h0, d[7:0]} << (8 * addr[1:0]);
          end
          default: be = 4'b1111;
        endcase
        exp_q.push_back('{1'b1, addr, be, d});
        model_mem[addr[31:2]] = merge_lanes(model_word(addr), d, be);
      end
      4'h6: if (cond_holds(f, m_flags)) pc = pc + {imm[29:0], 2'b00};
      4'h7: pc = m_regs[ra];
      default: done = 1'b1;
    endcase
  end
endtask

`endif

/* verif/cpu_core_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_core_tb import cpu_pkg::*; ();

  localparam int MUL_STAGES = 2;

  logic clk, reset_n, waitrequest;
  logic [31:0] readdata, address, writedata;
  logic read, write, halt;
  logic [3:0] byteenable;

  `include "cpu_ref_model.svh"

  logic [31:0] prog [$];
  logic [31:0] bus_mem [logic [29:0]];
  int cycles = 0;
  int limit = 1000000;
  logic busy = 1'b0;
  int wait_left;
  xfer_t held, got, expd;

  cpu_core #(.MUL_STAGES(MUL_STAGES), .RESET_PC(32'h100)) dut0 (
    .clk(clk), .reset_n(reset_n), .waitrequest(waitrequest), .readdata(readdata),
    .address(address), .read(read), .write(write), .writedata(writedata),
    .byteenable(byteenable), .halt(halt)
  );

  task automatic report_mismatch(string sig, logic [31:0] actual, logic [31:0] expected);
    $display("Mismatch at %0t: %s got %h expected %h", $time, sig, actual, expected);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic stop_with(string msg);
    $display("Error at %0t: %s", $time, msg);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  function automatic logic [31:0] enc_reg(op_t op, logic [2:0] f, logic [4:0] ra,
                                          logic [4:0] rb, logic [4:0] rc);
    return {op, f, ra, rb, rc, 10'd0};
  endfunction

  function automatic logic [31:0] enc_imm(op_t op, logic [2:0] f, logic [4:0] ra,
                                          logic [15:0] imm);
    return {op, f, ra, 4'd0, imm};
  endfunction

  function automatic logic [31:0] bus_word(logic [31:0] addr);
    if (bus_mem.exists(addr[31:2])) return bus_mem[addr[31:2]];
    return fill_word({addr[31:2], 2'b00});
  endfunction

  task automatic add_filler(int n);
    for (int i = 0; i < n; i++) begin
      prog.push_back(enc_reg(OP_ALU, 3'($urandom), 5'($urandom), 5'($urandom), 5'($urandom)));
    end
  endtask

  task automatic build_program();
    int sel, k;
    logic [1:0] sz;
    logic [4:0] rb;
    logic [31:0] off;
    while (prog.size() < 135) begin
      sel = $urandom % 10;
      rb = 5'($urandom % 31) + 5'd1;
      sz = 2'($urandom % 3);
      off = (sz == 2'd0) ? ($urandom % 64) * 4 : (sz == 2'd1) ? ($urandom % 128) * 2 : $urandom % 256;
      k = 1 + $urandom % 3;
      case (sel)
        0, 1, 2: add_filler(1);
        3: prog.push_back(enc_imm(OP_ALUI, 3'($urandom), 5'($urandom), 16'($urandom)));
        4: prog.push_back(enc_imm(OP_LDI, 3'd0, 5'($urandom), 16'($urandom)));
        5: prog.push_back(enc_reg(OP_MUL, {2'b00, 1'($urandom)}, 5'($urandom),
                                  5'($urandom), 5'($urandom)));
        6, 7: begin  // aligned access in the data region
          prog.push_back(enc_imm(OP_LDI, 3'd0, rb, 16'(32'h1000 + off)));
          if (sel == 6) prog.push_back(enc_reg(OP_LOAD, {1'($urandom), sz}, 5'($urandom), rb, 5'd0));
          else prog.push_back(enc_reg(OP_STORE, {1'b0, sz}, 5'($urandom), rb, 5'd0));
        end
        8: begin
          prog.push_back(enc_imm(OP_BRANCH, 3'($urandom % 6), 5'd0, 16'(k)));
          add_filler(k);
        end
        default: begin
          k = k - 1;  // skip 0 to 2
          prog.push_back(enc_imm(OP_LDI, 3'd0, rb, 16'(32'h100 + 4 * (prog.size() + 2 + k))));
          prog.push_back(enc_reg(OP_JR, 3'd0, rb, 5'd0, 5'd0));
          add_filler(k);
        end
      endcase
    end
    for (int r = 0; r < 32; r++) begin  // register dump, r31 is the base
      prog.push_back(enc_imm(OP_LDI, 3'd0, 5'd31, 16'(32'h2000 + 4 * r)));
      prog.push_back(enc_reg(OP_STORE, 3'd0, 5'(r), 5'd31, 5'd0));
    end
    prog.push_back({OP_HALT, 28'd0});
  endtask

  task automatic serve_bus();
    assert (!(read && write)) else stop_with("read and write are both high");
    got = '{write, address, byteenable, writedata};
    if (!(read || write)) begin
      assert (!busy) else stop_with("strobe dropped before the transfer completed");
      waitrequest = 1'b0;
      return;
    end
    assert (!halt) else stop_with("bus transfer started after halt");
    if (!busy) begin
      busy = 1'b1;
      wait_left = $urandom % 4;
      held = got;
    end else begin
      assert (got.addr === held.addr) else report_mismatch("address", got.addr, held.addr);
      assert (got.wr === held.wr) else report_mismatch("write", 32'(got.wr), 32'(held.wr));
      if (got.wr) begin
        assert (got.data === held.data) else report_mismatch("writedata", got.data, held.data);
        assert (got.be === held.be) else report_mismatch("byteenable", 32'(got.be), 32'(held.be));
      end
    end
    if (wait_left > 0) begin
      waitrequest = 1'b1;
      readdata = $urandom;
      wait_left--;
      return;
    end
    waitrequest = 1'b0;
    busy = 1'b0;
    assert (exp_q.size() != 0) else stop_with("bus transfer beyond the end of the program");
    expd = exp_q.pop_front();
    assert (got.wr === expd.wr) else report_mismatch("write", 32'(got.wr), 32'(expd.wr));
    assert (got.addr === expd.addr) else report_mismatch("address", got.addr, expd.addr);
    if (got.wr) begin
      assert (got.be === expd.be) else report_mismatch("byteenable", 32'(got.be), 32'(expd.be));
      assert (got.data === expd.data) else report_mismatch("writedata", got.data, expd.data);
      bus_mem[got.addr[31:2]] = merge_lanes(bus_word(got.addr), got.data, got.be);
    end else begin
      readdata = bus_word(got.addr);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > limit) stop_with("timeout, the core did not reach halt in time");
    end
  end

  initial begin
    reset_n = 1'b0;
    waitrequest = 1'b0;
    readdata = '0;
    void'($urandom(32'h8253_4ca6));
    build_program();
    for (int i = 0; i < prog.size(); i++) begin
      bus_mem[30'((32'h100 >> 2) + i)] = prog[i];
      model_mem[30'((32'h100 >> 2) + i)] = prog[i];
    end
    model_run();
    limit = prog.size() * (6 + MUL_STAGES + 3) + 500;
    repeat (8) @(posedge clk);
    #1;
    assert (!read && !write && !halt) else stop_with("strobes or halt high during reset");
    reset_n = 1'b1;
    while (!halt) begin
      @(posedge clk);
      #1;
      serve_bus();
    end
    repeat (20) begin  // nothing may move after halt
      @(posedge clk);
      #1;
      serve_bus();
    end
    for (int r = 0; r < 32; r++) begin
      assert (bus_word(32'h2000 + 4 * r) === m_regs[r])
        else report_mismatch($sformatf("dump r%0d", r), bus_word(32'h2000 + 4 * r), m_regs[r]);
    end
    if (exp_q.size() != 0 || !halt) begin
      stop_with("halt reached before all expected bus transfers");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* cpu_core.f */
+incdir+verif
source/cpu_pkg.sv
source/cpu_alu.sv
source/int_mul_unit.sv
source/register_file.sv
source/bus_lanes.sv
source/cpu_control.sv
source/cpu_core.sv
verif/cpu_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the cpu_core testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert \
  --top-module cpu_core_tb \
  -f cpu_core.f \
  -o sim_cpu_core

# the testbench stops with a non-zero status on failure, the log decides
./obj_dir/sim_cpu_core > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST PASS$" sim.log; then
  exit 0
else
  echo "simulation did not pass, see sim.log"
  exit 1
fi
